/* design/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and register width
`define DATA_WIDTH 32

// index into the 32-entry register file
`define REG_ADDR_WIDTH 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

/* design/isaPkg.sv */
package isaPkg;

	// major opcodes of the supported subset
	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opJ       = 6'b000010,
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opAddiu   = 6'b001001,
		opSlti    = 6'b001010,
		opAndi    = 6'b001100,
		opOri     = 6'b001101,
		opLui     = 6'b001111,
		opLb      = 6'b100000,
		opLw      = 6'b100011,
		opLbu     = 6'b100100,
		opSb      = 6'b101000,
		opSw      = 6'b101011
	} opcodeT;

	// function field under opSpecial
	typedef enum logic [5:0] {
		fnSll  = 6'b000000,
		fnSrl  = 6'b000010,
		fnJr   = 6'b001000,
		fnAddu = 6'b100001,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnSlt  = 6'b101010
	} functT;

	typedef struct packed {
		opcodeT     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT      funct;
	} rTypeT;

	typedef struct packed {
		opcodeT      opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeT;

	typedef struct packed {
		opcodeT      opcode;
		logic [25:0] target;
	} jTypeT;

	// one fetched word, seen through whichever format the opcode selects
	typedef union packed {
		rTypeT r;
		iTypeT i;
		jTypeT j;
	} instrT;

endpackage

/* design/pipePkg.sv */
package pipePkg;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluXor = 4'd4,
		aluSlt = 4'd5,
		aluSll = 4'd6,
		aluSrl = 4'd7,
		aluLui = 4'd8
	} aluOpT;

	// link writes pc+8
	typedef enum logic [1:0] {
		srcAlu  = 2'd0,
		srcLoad = 2'd1,
		srcLink = 2'd2
	} wbSrcT;

	typedef enum logic [1:0] {
		sizeWord  = 2'd0,
		sizeByte  = 2'd1,
		sizeUbyte = 2'd2
	} memSizeT;

	typedef enum logic [1:0] {
		fwdRf  = 2'd0,
		fwdMem = 2'd1,
		fwdWb  = 2'd2
	} fwdSelT;

endpackage

/* design/regFile.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module regFile (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddrA,
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddrB,
	input  logic                       wrEn,
	input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	input  logic [`DATA_WIDTH-1:0]     wrData,
	output logic [`DATA_WIDTH-1:0]     rdDataA,
	output logic [`DATA_WIDTH-1:0]     rdDataB
);

	// register 0 has no storage
	logic [`DATA_WIDTH-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// same-cycle writeback wins over the stored value
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

/* design/decodeUnit.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module decodeUnit (
	input  isaPkg::instrT              instr,
	input  logic [`DATA_WIDTH-1:0]     pc,
	input  logic [`DATA_WIDTH-1:0]     rsVal,
	input  logic [`DATA_WIDTH-1:0]     rtVal,
	output pipePkg::aluOpT             aluOp,
	output logic                       useImm,
	output logic [`DATA_WIDTH-1:0]     imm,
	output logic [`REG_ADDR_WIDTH-1:0] destReg,
	output logic                       regWrite,
	output logic                       memRead,
	output logic                       memWrite,
	output pipePkg::memSizeT           memSize,
	output pipePkg::wbSrcT             wbSrc,
	output logic                       usesRs,
	output logic                       usesRt,
	output logic                       isBranch,
	output logic                       takeJump,
	output logic [`DATA_WIDTH-1:0]     jumpTarget
);
	import isaPkg::*;
	import pipePkg::*;

	logic [`DATA_WIDTH-1:0] pcPlus4;
	logic [`DATA_WIDTH-1:0] signImm;
	logic                   zeroExt;
	logic                   upperExt;
	logic                   writesReg;
	logic                   operandsEqual;

	assign pcPlus4 = pc + 32'd4;
	assign signImm = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign operandsEqual = (rsVal == rtVal);

	always_comb begin
		aluOp = aluAdd;
		useImm = 1'b0;
		zeroExt = 1'b0;
		upperExt = 1'b0;
		writesReg = 1'b0;
		destReg = instr.i.rt;
		memRead = 1'b0;
		memWrite = 1'b0;
		memSize = sizeWord;
		wbSrc = srcAlu;
		usesRs = 1'b0;
		usesRt = 1'b0;
		isBranch = 1'b0;
		takeJump = 1'b0;
		jumpTarget = pcPlus4 + {signImm[`DATA_WIDTH-3:0], 2'b00};
		case (instr.r.opcode)
			opSpecial: begin
				destReg = instr.r.rd;
				writesReg = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
				case (instr.r.funct)
					fnAddu: aluOp = aluAdd;
					fnSubu: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnSlt: aluOp = aluSlt;
					fnSll: begin
						aluOp = aluSll;
						usesRs = 1'b0;
					end
					fnSrl: begin
						aluOp = aluSrl;
						usesRs = 1'b0;
					end
					fnJr: begin
						writesReg = 1'b0;
						usesRt = 1'b0;
						isBranch = 1'b1;
						takeJump = 1'b1;
						jumpTarget = rsVal;
					end
					default: begin
						writesReg = 1'b0;
						usesRs = 1'b0;
						usesRt = 1'b0;
					end
				endcase
			end
			opJ, opJal: begin
				takeJump = 1'b1;
				jumpTarget = {pcPlus4[31:28], instr.j.target, 2'b00};
				if (instr.j.opcode == opJal) begin
					writesReg = 1'b1;
					destReg = `REG_ADDR_WIDTH'(31);
					wbSrc = srcLink;
				end
			end
			opBeq, opBne: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				isBranch = 1'b1;
				takeJump = (instr.i.opcode == opBeq) ? operandsEqual : !operandsEqual;
			end
			opAddiu, opSlti, opAndi, opOri: begin
				usesRs = 1'b1;
				useImm = 1'b1;
				writesReg = 1'b1;
				case (instr.i.opcode)
					opSlti: aluOp = aluSlt;
					opAndi: aluOp = aluAnd;
					opOri: aluOp = aluOr;
					default: aluOp = aluAdd;
				endcase
				zeroExt = (instr.i.opcode == opAndi) || (instr.i.opcode == opOri);
			end
			opLui: begin
				aluOp = aluLui;
				useImm = 1'b1;
				upperExt = 1'b1;
				writesReg = 1'b1;
			end
			opLw, opLb, opLbu: begin
				usesRs = 1'b1;
				useImm = 1'b1;
				writesReg = 1'b1;
				memRead = 1'b1;
				wbSrc = srcLoad;
				if (instr.i.opcode == opLb) begin
					memSize = sizeByte;
				end else if (instr.i.opcode == opLbu) begin
					memSize = sizeUbyte;
				end
			end
			opSw, opSb: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				useImm = 1'b1;
				memWrite = 1'b1;
				memSize = (instr.i.opcode == opSb) ? sizeByte : sizeWord;
			end
			default: writesReg = 1'b0;
		endcase
	end

	assign imm = upperExt ? {instr.i.imm, 16'b0} :
		zeroExt ? {16'b0, instr.i.imm} : signImm;

	// r0 as destination never counts as a write
	assign regWrite = writesReg && (destReg != '0);

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module hazardUnit (
	input  logic [`REG_ADDR_WIDTH-1:0] idRs,
	input  logic [`REG_ADDR_WIDTH-1:0] idRt,
	input  logic                       idUsesRs,
	input  logic                       idUsesRt,
	input  logic                       idIsBranch,
	input  logic [`REG_ADDR_WIDTH-1:0] exRs,
	input  logic [`REG_ADDR_WIDTH-1:0] exRt,
	input  logic [`REG_ADDR_WIDTH-1:0] exDest,
	input  logic                       exRegWrite,
	input  logic                       exMemRead,
	input  logic [`REG_ADDR_WIDTH-1:0] memDest,
	input  logic                       memRegWrite,
	input  logic                       memMemRead,
	input  logic [`REG_ADDR_WIDTH-1:0] wbDest,
	input  logic                       wbRegWrite,
	output pipePkg::fwdSelT            fwdExA,
	output pipePkg::fwdSelT            fwdExB,
	output pipePkg::fwdSelT            fwdIdA,
	output pipePkg::fwdSelT            fwdIdB,
	output logic                       stall
);
	import pipePkg::*;

	logic memCanFwd;
	logic wbCanFwd;
	logic exHitsId;
	logic memLoadHitsId;

	// load data only exists once the word is back in writeback
	assign memCanFwd = memRegWrite && !memMemRead && memDest != '0;
	assign wbCanFwd = wbRegWrite && wbDest != '0;

	// memory is newer than writeback
	always_comb begin
		fwdExA = fwdRf;
		fwdExB = fwdRf;
		fwdIdA = fwdRf;
		fwdIdB = fwdRf;
		if (memCanFwd && memDest == exRs) begin
			fwdExA = fwdMem;
		end else if (wbCanFwd && wbDest == exRs) begin
			fwdExA = fwdWb;
		end
		if (memCanFwd && memDest == exRt) begin
			fwdExB = fwdMem;
		end else if (wbCanFwd && wbDest == exRt) begin
			fwdExB = fwdWb;
		end
		// writeback reaches decode through the register file bypass
		if (memCanFwd && memDest == idRs) begin
			fwdIdA = fwdMem;
		end
		if (memCanFwd && memDest == idRt) begin
			fwdIdB = fwdMem;
		end
	end

	assign exHitsId = exRegWrite && exDest != '0 &&
		((idUsesRs && exDest == idRs) || (idUsesRt && exDest == idRt));
	assign memLoadHitsId = memRegWrite && memMemRead && memDest != '0 &&
		((idUsesRs && memDest == idRs) || (idUsesRt && memDest == idRt));

	// load-use, or a branch whose operand is not yet in memory as an ALU value
	assign stall = (exHitsId && (exMemRead || idIsBranch)) || (memLoadHitsId && idIsBranch);

endmodule

/* design/execUnit.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module execUnit (
	input  pipePkg::aluOpT         aluOp,
	input  logic [`DATA_WIDTH-1:0] opA,
	input  logic [`DATA_WIDTH-1:0] opB,
	input  logic [4:0]             shamt,
	input  logic [`DATA_WIDTH-1:0] storeVal,
	output logic [1:0]             addrLow,
	input  pipePkg::memSizeT       memSize,
	output logic [`DATA_WIDTH-1:0] result,
	output logic [`DATA_WIDTH-1:0] storeData,
	output logic [3:0]             storeStrb
);
	import pipePkg::*;

	logic [`DATA_WIDTH-1:0] sum;
	logic                   lessThan;

	assign sum = opA + opB;
	assign addrLow = sum[1:0];
	assign lessThan = $signed(opA) < $signed(opB);

	always_comb begin
		case (aluOp)
			aluAdd: result = sum;
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluXor: result = opA ^ opB;
			aluSlt: result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
			aluSll: result = opB << shamt;
			aluSrl: result = opB >> shamt;
			// immediate arrives already shifted up
			aluLui: result = opB;
			default: result = sum;
		endcase
	end

	// byte stores go out on every lane, strobe picks the one
	always_comb begin
		if (memSize == sizeWord) begin
			storeData = storeVal;
			storeStrb = 4'b1111;
		end else begin
			storeData = {4{storeVal[7:0]}};
			storeStrb = 4'b0001 << addrLow;
		end
	end

endmodule

/* design/mipsCore.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module mipsCore (
	input  logic                       clk,
	input  logic                       rst,
	output logic                       fetchEn,
	output logic [`DATA_WIDTH-1:0]     fetchAddr,
	input  logic [`DATA_WIDTH-1:0]     instrWord,
	output logic                       memEn,
	output logic                       memWe,
	output logic [`DATA_WIDTH-1:0]     memAddr,
	output logic [`DATA_WIDTH-1:0]     memWdata,
	output logic [3:0]                 memStrb,
	input  logic [`DATA_WIDTH-1:0]     memRdata,
	output logic                       wbWen,
	output logic [`DATA_WIDTH-1:0]     wbPc,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData
);
	import isaPkg::*;
	import pipePkg::*;

	// fetch and decode
	logic [`DATA_WIDTH-1:0]     pc;
	logic [`DATA_WIDTH-1:0]     idPc;
	logic                       idValid;
	instrT                      idInstr;
	logic [`DATA_WIDTH-1:0]     rfRs;
	logic [`DATA_WIDTH-1:0]     rfRt;
	logic [`DATA_WIDTH-1:0]     idRsVal;
	logic [`DATA_WIDTH-1:0]     idRtVal;
	aluOpT                      decAluOp;
	logic                       decUseImm;
	logic [`DATA_WIDTH-1:0]     decImm;
	logic [`REG_ADDR_WIDTH-1:0] decDest;
	logic                       decRegWrite;
	logic                       decMemRead;
	logic                       decMemWrite;
	memSizeT                    decMemSize;
	wbSrcT                      decWbSrc;
	logic                       decUsesRs;
	logic                       decUsesRt;
	logic                       decIsBranch;
	logic                       takeJump;
	logic [`DATA_WIDTH-1:0]     jumpTarget;
	fwdSelT                     fwdExA;
	fwdSelT                     fwdExB;
	fwdSelT                     fwdIdA;
	fwdSelT                     fwdIdB;
	logic                       stall;

	// execute
	logic [`DATA_WIDTH-1:0]     exPc;
	aluOpT                      exAluOp;
	logic                       exUseImm;
	logic [`DATA_WIDTH-1:0]     exImm;
	logic [`DATA_WIDTH-1:0]     exRsVal;
	logic [`DATA_WIDTH-1:0]     exRtVal;
	logic [`REG_ADDR_WIDTH-1:0] exRs;
	logic [`REG_ADDR_WIDTH-1:0] exRt;
	logic [4:0]                 exShamt;
	logic [`REG_ADDR_WIDTH-1:0] exDest;
	logic                       exRegWrite;
	logic                       exMemRead;
	logic                       exMemWrite;
	memSizeT                    exMemSize;
	wbSrcT                      exWbSrc;
	logic [`DATA_WIDTH-1:0]     exOpA;
	logic [`DATA_WIDTH-1:0]     exRtFwd;
	logic [`DATA_WIDTH-1:0]     exOpB;
	logic [`DATA_WIDTH-1:0]     aluResult;
	logic [1:0]                 exAddrLow;
	logic [`DATA_WIDTH-1:0]     exStoreData;
	logic [3:0]                 exStoreStrb;
	logic [`DATA_WIDTH-1:0]     exResult;

	// memory
	logic [`DATA_WIDTH-1:0]     memPc;
	logic [`DATA_WIDTH-1:0]     memResult;
	logic [1:0]                 memAddrLow;
	logic [`DATA_WIDTH-1:0]     memStoreData;
	logic [3:0]                 memStoreStrb;
	logic [`REG_ADDR_WIDTH-1:0] memDest;
	logic                       memRegWrite;
	logic                       memMemRead;
	logic                       memMemWrite;
	memSizeT                    memMemSize;
	wbSrcT                      memWbSrc;

	// writeback
	logic [`DATA_WIDTH-1:0]     wbStagePc;
	logic [`DATA_WIDTH-1:0]     wbResult;
	logic [1:0]                 wbAddrLow;
	logic [`REG_ADDR_WIDTH-1:0] wbDest;
	logic                       wbRegWrite;
	memSizeT                    wbMemSize;
	wbSrcT                      wbSource;
	logic [7:0]                 loadByte;
	logic [`DATA_WIDTH-1:0]     loadVal;
	logic [`DATA_WIDTH-1:0]     wbValue;

	function automatic logic [`DATA_WIDTH-1:0] pickOperand(
		input fwdSelT                 sel,
		input logic [`DATA_WIDTH-1:0] rfVal,
		input logic [`DATA_WIDTH-1:0] memVal,
		input logic [`DATA_WIDTH-1:0] wbVal
	);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return rfVal;
		endcase
	endfunction

	// the slot after a branch is already being fetched when it resolves
	assign fetchEn = !stall;
	assign fetchAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
			idValid <= 1'b0;
		end else if (!stall) begin
			pc <= takeJump ? jumpTarget : pc + 32'd4;
			idValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			idPc <= pc;
		end
	end

	// all-zero word is sll r0 and decodes as nothing
	assign idInstr = idValid ? instrWord : '0;

	regFile uRegFile (
		.clk(clk), .rst(rst),
		.rdAddrA(idInstr.r.rs), .rdAddrB(idInstr.r.rt),
		.wrEn(wbRegWrite), .wrAddr(wbDest), .wrData(wbValue),
		.rdDataA(rfRs), .rdDataB(rfRt)
	);

	assign idRsVal = pickOperand(fwdIdA, rfRs, memResult, wbValue);
	assign idRtVal = pickOperand(fwdIdB, rfRt, memResult, wbValue);

	decodeUnit uDecode (
		.instr(idInstr), .pc(idPc), .rsVal(idRsVal), .rtVal(idRtVal),
		.aluOp(decAluOp), .useImm(decUseImm), .imm(decImm), .destReg(decDest),
		.regWrite(decRegWrite), .memRead(decMemRead), .memWrite(decMemWrite),
		.memSize(decMemSize), .wbSrc(decWbSrc), .usesRs(decUsesRs), .usesRt(decUsesRt),
		.isBranch(decIsBranch), .takeJump(takeJump), .jumpTarget(jumpTarget)
	);

	hazardUnit uHazard (
		.idRs(idInstr.r.rs), .idRt(idInstr.r.rt),
		.idUsesRs(decUsesRs), .idUsesRt(decUsesRt), .idIsBranch(decIsBranch),
		.exRs(exRs), .exRt(exRt), .exDest(exDest),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.memDest(memDest), .memRegWrite(memRegWrite), .memMemRead(memMemRead),
		.wbDest(wbDest), .wbRegWrite(wbRegWrite),
		.fwdExA(fwdExA), .fwdExB(fwdExB), .fwdIdA(fwdIdA), .fwdIdB(fwdIdB),
		.stall(stall)
	);

	// a stall turns the execute slot into a bubble
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
		end else begin
			exRegWrite <= decRegWrite;
			exMemRead <= decMemRead;
			exMemWrite <= decMemWrite;
		end
	end

	always_ff @(posedge clk) begin
		exPc <= idPc;
		exAluOp <= decAluOp;
		exUseImm <= decUseImm;
		exImm <= decImm;
		exRsVal <= idRsVal;
		exRtVal <= idRtVal;
		exRs <= idInstr.r.rs;
		exRt <= idInstr.r.rt;
		exShamt <= idInstr.r.shamt;
		exDest <= decDest;
		exMemSize <= decMemSize;
		exWbSrc <= decWbSrc;
	end

	assign exOpA = pickOperand(fwdExA, exRsVal, memResult, wbValue);
	assign exRtFwd = pickOperand(fwdExB, exRtVal, memResult, wbValue);
	assign exOpB = exUseImm ? exImm : exRtFwd;

	execUnit uExec (
		.aluOp(exAluOp), .opA(exOpA), .opB(exOpB), .shamt(exShamt),
		.storeVal(exRtFwd), .addrLow(exAddrLow), .memSize(exMemSize),
		.result(aluResult), .storeData(exStoreData), .storeStrb(exStoreStrb)
	);

	// link address rides the result path so it forwards like any ALU value
	assign exResult = (exWbSrc == srcLink) ? exPc + 32'd8 : aluResult;

	always_ff @(posedge clk) begin
		if (rst) begin
			memRegWrite <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
		end else begin
			memRegWrite <= exRegWrite;
			memMemRead <= exMemRead;
			memMemWrite <= exMemWrite;
		end
	end

	always_ff @(posedge clk) begin
		memPc <= exPc;
		memResult <= exResult;
		memAddrLow <= exAddrLow;
		memStoreData <= exStoreData;
		memStoreStrb <= exStoreStrb;
		memDest <= exDest;
		memMemSize <= exMemSize;
		memWbSrc <= exWbSrc;
	end

	assign memEn = memMemRead || memMemWrite;
	assign memWe = memMemWrite;
	assign memAddr = {memResult[`DATA_WIDTH-1:2], 2'b00};
	assign memWdata = memStoreData;
	assign memStrb = memMemWrite ? memStoreStrb : 4'b0000;

	always_ff @(posedge clk) begin
		if (rst) begin
			wbRegWrite <= 1'b0;
		end else begin
			wbRegWrite <= memRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		wbStagePc <= memPc;
		wbResult <= memResult;
		wbAddrLow <= memAddrLow;
		wbDest <= memDest;
		wbMemSize <= memMemSize;
		wbSource <= memWbSrc;
	end

	// read word lands here, one edge after the memory stage
	assign loadByte = memRdata[{wbAddrLow, 3'b000} +: 8];

	always_comb begin
		case (wbMemSize)
			sizeByte: loadVal = {{(`DATA_WIDTH-8){loadByte[7]}}, loadByte};
			sizeUbyte: loadVal = {{(`DATA_WIDTH-8){1'b0}}, loadByte};
			default: loadVal = memRdata;
		endcase
	end

	assign wbValue = (wbSource == srcLoad) ? loadVal : wbResult;

	// trace is the registered commit
	always_ff @(posedge clk) begin
		if (rst) begin
			wbWen <= 1'b0;
		end else begin
			wbWen <= wbRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		wbPc <= wbStagePc;
		wbReg <= wbDest;
		wbData <= wbValue;
	end

endmodule

/* tests/wbChecker.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module wbChecker (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wbWen,
	input  logic [`DATA_WIDTH-1:0]     wbPc,
	input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`DATA_WIDTH-1:0]     wbData,
	output int                         errCount,
	output int                         checkedCount,
	output logic                       done
);

	logic [`DATA_WIDTH-1:0]     expPc [0:63];
	logic [`REG_ADDR_WIDTH-1:0] expReg [0:63];
	logic [`DATA_WIDTH-1:0]     expData [0:63];
	int                         expTotal;

	task automatic compareEntry(input int k);
		if (wbPc !== expPc[k]) begin
			$display("** Error: wbPc expected %h, got %h (entry %0d)", expPc[k], wbPc, k);
			errCount++;
		end
		if (wbReg !== expReg[k]) begin
			$display("** Error: wbReg expected %h, got %h (entry %0d)", expReg[k], wbReg, k);
			errCount++;
		end
		if (wbData !== expData[k]) begin
			$display("** Error: wbData expected %h, got %h (entry %0d)", expData[k], wbData, k);
			errCount++;
		end
		checkedCount++;
	endtask

	// trace settles after the rising edge, so sample on the falling one
	initial begin : walkTrace
		int fd;
		int n;
		int idx;
		int tailCycles;
		string line;
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] r;
		logic [`DATA_WIDTH-1:0] d;
		errCount = 0;
		checkedCount = 0;
		done = 1'b0;
		expTotal = 0;
		idx = 0;
		tailCycles = 0;
		fd = $fopen("tests/core_stim.txt", "r");
		if (fd == 0) begin
			$display("checker cannot open tests/core_stim.txt");
			errCount++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 2 && line[0] == "E" && expTotal < 64) begin
					n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, r, d);
					expPc[expTotal] = a;
					expReg[expTotal] = r[`REG_ADDR_WIDTH-1:0];
					expData[expTotal] = d;
					expTotal++;
				end
			end
			$fclose(fd);
		end
		forever begin
			@(negedge clk);
			if (!rst && !done) begin
				if (wbWen && idx < expTotal) begin
					compareEntry(idx);
					idx++;
				end else if (wbWen) begin
					$display("unexpected writeback after the last expected entry: pc %h reg %0d",
						wbPc, wbReg);
					errCount++;
				end
				if (idx >= expTotal) begin
					tailCycles++;
					if (tailCycles >= 20) begin
						done = 1'b1;
					end
				end
			end
		end
	end

endmodule

/* tests/tbTop.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module tbTop;

	logic                       clk;
	logic                       rst;
	logic                       fetchEn;
	logic [`DATA_WIDTH-1:0]     fetchAddr;
	logic [`DATA_WIDTH-1:0]     instrWord = '0;
	logic                       memEn;
	logic                       memWe;
	logic [`DATA_WIDTH-1:0]     memAddr;
	logic [`DATA_WIDTH-1:0]     memWdata;
	logic [3:0]                 memStrb;
	logic [`DATA_WIDTH-1:0]     memRdata = '0;
	logic                       wbWen;
	logic [`DATA_WIDTH-1:0]     wbPc;
	logic [`REG_ADDR_WIDTH-1:0] wbReg;
	logic [`DATA_WIDTH-1:0]     wbData;

	logic [`DATA_WIDTH-1:0] imem [0:255];
	logic [`DATA_WIDTH-1:0] dmem [0:255];
	int                     expTotal = 0;
	int                     errCount;
	int                     checkedCount;
	logic                   checkDone;

	mipsCore i_dut (
		.clk(clk), .rst(rst),
		.fetchEn(fetchEn), .fetchAddr(fetchAddr), .instrWord(instrWord),
		.memEn(memEn), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
		.memStrb(memStrb), .memRdata(memRdata),
		.wbWen(wbWen), .wbPc(wbPc), .wbReg(wbReg), .wbData(wbData)
	);

	wbChecker uChecker (
		.clk(clk), .rst(rst),
		.wbWen(wbWen), .wbPc(wbPc), .wbReg(wbReg), .wbData(wbData),
		.errCount(errCount), .checkedCount(checkedCount), .done(checkDone)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

	// both memories answer one edge after the request
	initial begin : memoryModel
		int fd;
		int n;
		string line;
		logic [`DATA_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] word;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = {~i[15:0], i[15:0]};
		end
		fd = $fopen("tests/core_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/core_stim.txt");
			$display("Errors found");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 2 && line[0] == "I") begin
					n = $sscanf(line.substr(2, line.len() - 1), "%h %h", addr, word);
					imem[addr[9:2]] = word;
				end else if (n > 2 && line[0] == "D") begin
					n = $sscanf(line.substr(2, line.len() - 1), "%h %h", addr, word);
					dmem[addr[9:2]] = word;
				end else if (n > 2 && line[0] == "E") begin
					expTotal++;
				end
			end
			$fclose(fd);
			forever begin
				@(posedge clk);
				if (fetchEn) begin
					instrWord <= imem[fetchAddr[9:2]];
				end
				if (memEn && memWe) begin
					word = dmem[memAddr[9:2]];
					for (int b = 0; b < 4; b++) begin
						if (memStrb[b]) begin
							word[8*b +: 8] = memWdata[8*b +: 8];
						end
					end
					dmem[memAddr[9:2]] = word;
				end else if (memEn) begin
					memRdata <= dmem[memAddr[9:2]];
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		@(negedge rst);
		limit = 100 + 12 * expTotal;
		repeat (limit) @(posedge clk);
		$display("timeout: trace still incomplete after %0d cycles", limit);
		$display("Errors found");
		$finish;
	end

	initial begin
		wait (checkDone === 1'b1);
		$display("%0d trace entries checked, %0d errors", checkedCount, errCount);
		if (errCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* tests/core_stim.txt */
# I addr word = program word, D addr word = initial data word
# E pc reg data = expected writeback trace in program order (all hex)
I 00000000 24010005
I 00000004 24220003
I 00000008 00411823
I 0000000C 3C048000
I 00000010 348400F0
I 00000014 0081282A
I 00000018 00833026
I 0000001C 00063900
I 00000020 00064702
I 00000024 24200007
I 00000028 00014825
I 0000002C 288AFFFF
I 00000030 30CBFFFF
I 00000034 240C0100
I 00000038 AD860000
I 0000003C A1810001
I 00000040 A1840003
I 00000044 8D8D0000
I 00000048 01A17021
I 0000004C 818F0003
I 00000050 91900003
I 00000054 81910001
I 00000058 81920004
I 0000005C 24130005
I 00000060 12610002
I 00000064 24140001
I 00000068 24140002
I 0000006C 24150009
I 00000070 24160003
I 00000074 16A10002
I 00000078 24170004
I 0000007C 24170006
I 00000080 8D980004
I 00000084 13000003
I 00000088 24190007
I 0000008C 241A0008
I 00000090 0C000029
I 00000094 241B000A
I 00000098 241C000B
I 0000009C 08000027
I 000000A0 00000000
I 000000A4 27FD0004
I 000000A8 03E00008
I 000000AC 241E000C
D 00000104 11223380
E 00000000 01 00000005
E 00000004 02 00000008
E 00000008 03 00000003
E 0000000C 04 80000000
E 00000010 04 800000F0
E 00000014 05 00000001
E 00000018 06 800000F3
E 0000001C 07 00000F30
E 00000020 08 00000008
E 00000028 09 00000005
E 0000002C 0A 00000001
E 00000030 0B 000000F3
E 00000034 0C 00000100
E 00000044 0D F00005F3
E 00000048 0E F00005F8
E 0000004C 0F FFFFFFF0
E 00000050 10 000000F0
E 00000054 11 00000005
E 00000058 12 FFFFFF80
E 0000005C 13 00000005
E 00000064 14 00000001
E 0000006C 15 00000009
E 00000070 16 00000003
E 00000078 17 00000004
E 00000080 18 11223380
E 00000088 19 00000007
E 0000008C 1A 00000008
E 00000090 1F 00000098
E 00000094 1B 0000000A
E 000000A4 1D 0000009C
E 000000AC 1E 0000000C
E 00000098 1C 0000000B

/* compile.f */
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/regFile.sv
design/decodeUnit.sv
design/hazardUnit.sv
design/execUnit.sv
design/mipsCore.sv
tests/wbChecker.sv
tests/tbTop.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tbTop -f compile.f -o simTb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/simTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "No errors"; then
	exit 0
fi
exit 1
